// File: logic/addPkg.sv
package addPkg;

  typedef logic [31:0] dataT;

  typedef enum logic [1:0] {
    opAdd       = 2'd0,  // a + b
    opSub       = 2'd1,  // a + ~b + 1
    opAddCarry  = 2'd2,  // a + b + carry
    opSubBorrow = 2'd3   // a + ~b + carry
  } opcodeT;

  // carry sits in bit 0, negative in bit 3
  typedef struct packed {
    logic negative;
    logic zero;
    logic overflow;
    logic carry;  // 1 means no borrow on subtract
  } flagsT;

  typedef enum logic [2:0] {
    regOperandA = 3'd0,
    regOperandB = 3'd1,
    regControl  = 3'd2,
    regResult   = 3'd3,  // read-only
    regFlags    = 3'd4   // read-only
  } regAddrT;

  localparam int goBit    = 8;   // write-only bit of regControl
  localparam int readyBit = 31;  // in regFlags

endpackage

// File: logic/arithIf.sv
interface arithIf;
  import addPkg::*;

  logic   start;     // one-cycle launch pulse
  opcodeT opcode;
  dataT   operandA;
  dataT   operandB;
  dataT   result;
  flagsT  flags;
  logic   done;      // one cycle after start

  modport regs (
    output start, opcode, operandA, operandB,
    input  result, flags, done
  );

  modport core (
    input  start, opcode, operandA, operandB,
    output result, flags, done
  );

endinterface

// File: logic/claGroup4.sv
module claGroup4 (
  input  logic [3:0] x,
  input  logic [3:0] y,
  input  logic       carryIn,
  output logic [3:0] sum,
  output logic       groupPropagate,
  output logic       groupGenerate
);

  logic [3:0] p;
  logic [3:0] g;
  logic [3:0] c;  // carry into each bit

  assign p = x ^ y;
  assign g = x & y;

  // every carry comes straight from carryIn
  assign c[0] = carryIn;
  assign c[1] = g[0] | (p[0] & carryIn);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & carryIn);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & carryIn);

  assign sum = p ^ c;

  assign groupPropagate = &p;
  assign groupGenerate  = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                        | (p[3] & p[2] & p[1] & g[0]);

endmodule

// File: logic/claBlock16.sv
module claBlock16 (
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        carryIn,
  output logic [15:0] sum,
  output logic        blockPropagate,
  output logic        blockGenerate
);

  logic [3:0] groupP;
  logic [3:0] groupG;
  logic [3:0] groupC;  // carry into each group

  for (genvar i = 0; i < 4; i++) begin : gGroup
    claGroup4 u_group (
      .x              (a[4*i +: 4]),
      .y              (b[4*i +: 4]),
      .carryIn        (groupC[i]),
      .sum            (sum[4*i +: 4]),
      .groupPropagate (groupP[i]),
      .groupGenerate  (groupG[i])
    );
  end

  // second level lookahead
  assign groupC[0] = carryIn;
  assign groupC[1] = groupG[0] | (groupP[0] & carryIn);
  assign groupC[2] = groupG[1] | (groupP[1] & groupG[0]) | (groupP[1] & groupP[0] & carryIn);
  assign groupC[3] = groupG[2] | (groupP[2] & groupG[1]) | (groupP[2] & groupP[1] & groupG[0])
                   | (groupP[2] & groupP[1] & groupP[0] & carryIn);

  assign blockPropagate = &groupP;
  assign blockGenerate  = groupG[3] | (groupP[3] & groupG[2])
                        | (groupP[3] & groupP[2] & groupG[1])
                        | (groupP[3] & groupP[2] & groupP[1] & groupG[0]);

endmodule

// File: logic/claAdder32.sv
module claAdder32 (
  input  addPkg::dataT a,
  input  addPkg::dataT b,  // already inverted for subtract
  input  logic         carryIn,
  output addPkg::dataT sum,
  output logic         carryOut,
  output logic         overflow
);

  logic lowP, lowG;
  logic highP, highG;
  logic midCarry;  // into bit 16

  claBlock16 u_low (
    .a              (a[15:0]),
    .b              (b[15:0]),
    .carryIn        (carryIn),
    .sum            (sum[15:0]),
    .blockPropagate (lowP),
    .blockGenerate  (lowG)
  );

  claBlock16 u_high (
    .a              (a[31:16]),
    .b              (b[31:16]),
    .carryIn        (midCarry),
    .sum            (sum[31:16]),
    .blockPropagate (highP),
    .blockGenerate  (highG)
  );

  assign midCarry = lowG | (lowP & carryIn);
  assign carryOut = highG | (highP & lowG) | (highP & lowP & carryIn);

  // same operand signs, different result sign
  assign overflow = (a[31] == b[31]) && (sum[31] != a[31]);

endmodule

// File: logic/arithCore.sv
module arithCore (
  input logic clk,
  input logic reset,
  arithIf.core bus
);
  import addPkg::*;

  dataT bOperand;
  dataT sum;
  logic carryIn;
  logic carryOut;
  logic overflow;

  // chained ops reuse the stored carry
  always_comb begin
    bOperand = bus.operandB;
    carryIn  = 1'b0;
    unique case (bus.opcode)
      opAdd: begin
        carryIn = 1'b0;
      end
      opSub: begin
        bOperand = ~bus.operandB;
        carryIn  = 1'b1;
      end
      opAddCarry: begin
        carryIn = bus.flags.carry;
      end
      opSubBorrow: begin
        bOperand = ~bus.operandB;
        carryIn  = bus.flags.carry;
      end
    endcase
  end

  claAdder32 u_adder (
    .a        (bus.operandA),
    .b        (bOperand),
    .carryIn  (carryIn),
    .sum      (sum),
    .carryOut (carryOut),
    .overflow (overflow)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      bus.result <= '0;
      bus.flags  <= '0;
      bus.done   <= 1'b0;
    end else begin
      bus.done <= bus.start;  // fixed one-cycle latency
      if (bus.start) begin
        bus.result         <= sum;
        bus.flags.carry    <= carryOut;
        bus.flags.overflow <= overflow;
        bus.flags.zero     <= (sum == '0);
        bus.flags.negative <= sum[31];
      end
    end
  end

endmodule

// File: logic/arithRegs.sv
module arithRegs (
  input  logic         clk,
  input  logic         reset,
  input  logic         cyc,
  input  logic         stb,
  input  logic         we,
  input  logic [31:0]  adr,
  input  addPkg::dataT datIn,
  output addPkg::dataT datOut,
  output logic         ack,
  arithIf.regs         bus
);
  import addPkg::*;

  regAddrT regAddr;
  logic    request;  // new request not yet acked
  logic    launch;   // go written this cycle
  logic    ready;
  dataT    resultQ;
  flagsT   flagsQ;
  dataT    readData;

  assign regAddr = regAddrT'(adr[4:2]);
  assign request = cyc & stb & ~ack;
  assign launch  = request & we & (regAddr == regControl) & datIn[goBit];

  always_ff @(posedge clk) begin
    if (reset) begin
      ack       <= 1'b0;
      bus.start <= 1'b0;
    end else begin
      ack       <= request;  // never two in a row
      bus.start <= launch;
    end
  end

  // writes land on the edge that raises ack
  always_ff @(posedge clk) begin
    if (request && we) begin
      case (regAddr)
        regOperandA: bus.operandA <= datIn;
        regOperandB: bus.operandB <= datIn;
        regControl:  bus.opcode   <= opcodeT'(datIn[1:0]);
        default: ;  // result and flags are read-only
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ready   <= 1'b0;
      resultQ <= '0;
      flagsQ  <= '0;
    end else begin
      if (bus.done) begin
        resultQ <= bus.result;
        flagsQ  <= bus.flags;
      end
      if (launch) begin
        ready <= 1'b0;  // a new go wins over a late done
      end else if (bus.done) begin
        ready <= 1'b1;
      end
    end
  end

  always_comb begin
    readData = '0;
    case (regAddr)
      regOperandA: readData = bus.operandA;
      regOperandB: readData = bus.operandB;
      regControl:  readData[1:0] = bus.opcode;  // go reads 0
      regResult:   readData = resultQ;
      regFlags: begin
        readData[3:0]     = flagsQ;
        readData[readyBit] = ready;
      end
      default:     readData = '0;  // unmapped
    endcase
  end

  assign datOut = readData;  // valid while ack is high

endmodule

// File: logic/arithTop.sv
module arithTop (
  input  logic         clk,
  input  logic         reset,
  input  logic         cyc,
  input  logic         stb,
  input  logic         we,
  input  logic [31:0]  adr,
  input  addPkg::dataT datIn,
  output addPkg::dataT datOut,
  input  logic [3:0]   sel,  // partial selects act as full words
  output logic         ack
);

  arithIf u_bus ();

  arithRegs u_regs (
    .clk    (clk),
    .reset  (reset),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .datIn  (datIn),
    .datOut (datOut),
    .ack    (ack),
    .bus    (u_bus.regs)
  );

  arithCore u_core (
    .clk   (clk),
    .reset (reset),
    .bus   (u_bus.core)
  );

endmodule

// File: verification/arithTb.sv
module arithTb;
  import addPkg::*;

  localparam int numTable   = 11;
  localparam int numRandom  = 24;
  localparam int numRows    = numTable + numRandom;
  localparam int cycleLimit = numRows * 40;

  typedef struct packed {
    opcodeT op;
    dataT   a;
    dataT   b;
    dataT   res;
    flagsT  flg;
  } rowT;

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [31:0] adr;
  dataT        datIn;
  dataT        datOut;
  logic [3:0]  sel;
  logic        ack;

  rowT         rows [numRows];
  logic [15:0] lfsr;
  logic        modelCarry;  // stored carry as the reference model sees it
  int          passCount;
  int          failCount;
  int          cycleCount;

  arithTop u_arithTop (
    .clk    (clk),
    .reset  (reset),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .datIn  (datIn),
    .datOut (datOut),
    .sel    (sel),
    .ack    (ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("run timed out after %0d cycles, the DUT never finished the test list", cycleCount);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] byteAddress(input regAddrT r);
    return {27'd0, r, 2'b00};  // word index sits in adr[4:2]
  endfunction

  // taps 16 14 13 11
  function automatic logic lfsrBit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic dataT randomWord(input int n);
    dataT word;
    word = '0;
    for (int i = 0; i < n; i++) begin
      word = {word[30:0], lfsrBit()};
    end
    return word;
  endfunction

  // 33-bit reference of the opcode rules
  function automatic void modelOperation(input opcodeT op, input dataT a, input dataT b,
                                         output dataT res, output flagsT flg);
    logic [32:0] wide;
    logic        cin;
    logic        carryInto31;
    dataT        bEff;
    bEff = (op == opSub || op == opSubBorrow) ? ~b : b;
    case (op)
      opAdd:   cin = 1'b0;
      opSub:   cin = 1'b1;
      default: cin = modelCarry;
    endcase
    wide         = {1'b0, a} + {1'b0, bEff} + {32'd0, cin};
    res          = wide[31:0];
    carryInto31  = a[31] ^ bEff[31] ^ res[31];
    flg.carry    = wide[32];
    flg.overflow = carryInto31 ^ wide[32];  // top two carries differ
    flg.zero     = (res == '0);
    flg.negative = res[31];
    modelCarry   = wide[32];
  endfunction

  task automatic setRow(input int idx, input opcodeT op, input dataT a, input dataT b,
                        input dataT res, input flagsT flg);
    rows[idx] = '{op, a, b, res, flg};
  endtask

  task automatic wbWrite(input logic [31:0] addr, input dataT data);
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = addr;
    datIn = data;
    @(negedge clk);
    while (!ack) @(negedge clk);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wbRead(input logic [31:0] addr, output dataT data);
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = addr;
    @(negedge clk);
    while (!ack) @(negedge clk);
    data = datOut;  // valid while ack is high
    cyc  = 1'b0;
    stb  = 1'b0;
  endtask

  task automatic waitReady(output dataT flagsWord);
    flagsWord = '0;
    while (!flagsWord[readyBit]) wbRead(byteAddress(regFlags), flagsWord);
  endtask

  task automatic checkData(input string what, input dataT got, input dataT exp);
    if (got === exp) begin
      passCount++;
      $display("pass  %s = %h", what, got);
    end else begin
      failCount++;
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkFlags(input string what, input flagsT got, input flagsT exp);
    if (got === exp) begin
      passCount++;
      $display("pass  %s = %b (nzvc)", what, got);
    end else begin
      failCount++;
      $display("** Error at time %0t: %s is %b, expected %b (nzvc)", $time, what, got, exp);
    end
  endtask

  task automatic exerciseRegisters();
    dataT word;
    wbWrite(byteAddress(regOperandA), 32'hA5A5A5A5);
    wbWrite(byteAddress(regOperandB), 32'h3C3C3C3C);
    wbRead(byteAddress(regOperandA), word);
    checkData("operand A readback", word, 32'hA5A5A5A5);
    wbRead(byteAddress(regOperandB), word);
    checkData("operand B readback", word, 32'h3C3C3C3C);
    wbWrite(byteAddress(regControl), 32'h0000_0101);  // go with opSub
    waitReady(word);
    wbRead(byteAddress(regControl), word);
    checkData("control readback, go bit clear", word, 32'h0000_0001);
    wbWrite(byteAddress(regResult), 32'hDEADBEEF);
    wbRead(byteAddress(regResult), word);
    checkData("result after write attempt", word, 32'h69696969);
    wbRead(32'h0000_0014, word);
    checkData("unmapped 0x14", word, 32'h0);
    wbRead(32'h0000_001C, word);
    checkData("unmapped 0x1c", word, 32'h0);
  endtask

  task automatic runRow(input int idx);
    opcodeT op;
    dataT   resWord;
    dataT   flagsWord;
    dataT   refRes;
    dataT   expRes;
    flagsT  refFlags;
    flagsT  expFlags;
    string  tag;
    op = rows[idx].op;
    modelOperation(op, rows[idx].a, rows[idx].b, refRes, refFlags);
    expRes   = (idx < numTable) ? rows[idx].res : refRes;
    expFlags = (idx < numTable) ? rows[idx].flg : refFlags;
    tag      = $sformatf("row %0d %s", idx, op.name());
    wbWrite(byteAddress(regOperandA), rows[idx].a);
    wbWrite(byteAddress(regOperandB), rows[idx].b);
    wbWrite(byteAddress(regControl), {23'd0, 1'b1, 6'd0, op});
    waitReady(flagsWord);
    wbRead(byteAddress(regResult), resWord);
    checkData({tag, " result"}, resWord, expRes);
    checkFlags({tag, " flags"}, flagsT'(flagsWord[3:0]), expFlags);
  endtask

  initial begin
    dataT word;
    clk        = 1'b0;
    reset      = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    datIn      = '0;
    sel        = 4'hF;
    lfsr       = 16'd9;
    modelCarry = 1'b0;
    passCount  = 0;
    failCount  = 0;
    setRow(0,  opAdd,       32'h00000000, 32'h00000000, 32'h00000000, 4'b0100);
    setRow(1,  opAdd,       32'hFFFFFFFF, 32'h00000001, 32'h00000000, 4'b0101);
    setRow(2,  opAdd,       32'h0000FFFF, 32'h00000001, 32'h00010000, 4'b0000);
    setRow(3,  opAdd,       32'h7FFFFFFF, 32'h00000001, 32'h80000000, 4'b1010);
    setRow(4,  opSub,       32'h12345678, 32'h12345678, 32'h00000000, 4'b0101);
    setRow(5,  opSub,       32'h00000005, 32'h00000007, 32'hFFFFFFFE, 4'b1000);
    setRow(6,  opSub,       32'h80000000, 32'h00000001, 32'h7FFFFFFF, 4'b0011);
    setRow(7,  opAdd,       32'hFFFFFFFF, 32'h00000001, 32'h00000000, 4'b0101);  // 64-bit low
    setRow(8,  opAddCarry,  32'h00000001, 32'h00000002, 32'h00000004, 4'b0000);  // high word
    setRow(9,  opSub,       32'h00000000, 32'h00000001, 32'hFFFFFFFF, 4'b1000);  // 64-bit low
    setRow(10, opSubBorrow, 32'h00000005, 32'h00000001, 32'h00000003, 4'b0001);  // high word
    for (int i = numTable; i < numRows; i++) begin
      word = randomWord(2);
      setRow(i, opcodeT'(word[1:0]), randomWord(32), randomWord(32), '0, '0);
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;
    wbRead(byteAddress(regFlags), word);
    checkData("flags after reset, ready clear", word, 32'h0);
    wbRead(byteAddress(regResult), word);
    checkData("result after reset", word, 32'h0);
    exerciseRegisters();
    for (int i = 0; i < numRows; i++) begin
      runRow(i);
    end
    $display("%0d checks passed, %0d checks failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
logic/addPkg.sv
logic/arithIf.sv
logic/claGroup4.sv
logic/claBlock16.sv
logic/claAdder32.sv
logic/arithCore.sv
logic/arithRegs.sv
logic/arithTop.sv
verification/arithTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = arithTb
FILELIST  = build.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)
